// File: build.f
verilog/fpi_pkg.sv
verilog/fam_ifs.sv
verilog/fp_issue.sv
verilog/fam_queue.sv
verilog/fam_mul.sv
verilog/fpi_top.sv
dv/fpi_asserts.sv
dv/fpi_tb.sv

// File: dv/fpi_asserts.sv
`timescale 1ns/10ps

module fpi_asserts
   import fpi_pkg::*;
(
   input logic               clk,
   input logic               reset,
   input logic               instr_valid_i,
   input logic               instr_ready_o,
   input logic [XLEN_GP-1:0] instr_i,
   input logic               wb_valid_o,
   input logic [XLEN_GP-1:0] wb_data_o
);

   // No writeback right out of reset
   wb_quiet_after_reset: assert property (@(posedge clk) reset |=> !wb_valid_o)
      else $error("wb_valid_o high in the cycle after reset");

   instr_held_while_stalled: assert property (@(posedge clk) disable iff (reset)
      (instr_valid_i && !instr_ready_o) |=> $stable(instr_i))
      else $error("instr_i changed while the DUT stalled");

   wb_data_known: assert property (@(posedge clk) disable iff (reset)
      wb_valid_o |-> !$isunknown(wb_data_o))
      else $error("wb_data_o unknown with wb_valid_o high");

endmodule

bind fpi_top fpi_asserts u_fpi_asserts (
   .clk           (clk),
   .reset         (reset),
   .instr_valid_i (instr_valid_i),
   .instr_ready_o (instr_ready_o),
   .instr_i       (instr_i),
   .wb_valid_o    (wb_valid_o),
   .wb_data_o     (wb_data_o)
);

// File: dv/fpi_stimulus.txt
# instr_word int_operand dest expected_value to_int
# dest is the f or x register number, to_int 1 means an integer destination
F00000D3 3FC00000 01 3FC00000 0
F0000153 C0000000 02 C0000000 0
F00001D3 7FC00000 03 7FC00000 0
F0000253 7F800001 04 7F800001 0
F00002D3 40400000 05 40400000 0
E0010553 00000000 0A C0000000 1
20208353 00000000 06 BFC00000 0
202093D3 00000000 07 3FC00000 0
20212453 00000000 08 40000000 0
208414D3 00000000 09 C0000000 0
2024A553 00000000 0A 40000000 0
E00505D3 00000000 0B 40000000 1
282085D3 00000000 0B C0000000 0
28209653 00000000 0C 3FC00000 0
285186D3 00000000 0D 40400000 0
28319753 00000000 0E 7FC00000 0
00102673 00000000 0C 00000000 1
281217D3 00000000 0F 3FC00000 0
001026F3 00000000 0D 00000010 1
F00008D3 3FAAAAAB 11 3FAAAAAB 0
10589853 00000000 10 40800000 0
00102773 00000000 0E 00000011 1
F0000953 40000000 12 40000000 0
105919D3 00000000 13 40C00000 0
10528A53 00000000 14 41100000 0
20109AD3 00000000 15 BFC00000 0
11291B53 00000000 16 40800000 0
11209BD3 00000000 17 40400000 0
28129C53 00000000 18 40400000 0
2029ACD3 00000000 19 C0C00000 0
116A1D53 00000000 1A 42100000 0
F0000D53 12345678 1A 12345678 0
E00D07D3 00000000 0F 12345678 1
F0000DD3 7F000000 1B 7F000000 0
11BD9E53 00000000 1C 7F7FFFFF 0
F0000ED3 00800000 1D 00800000 0
11DE9F53 00000000 1E 00000000 0
F0000FD3 7F800000 1F 7F800000 0
F0000053 00000000 00 00000000 0
100F91D3 00000000 03 7FC00000 0
00102873 00000000 10 00000017 1

// File: dv/fpi_tb.sv
`timescale 1ns/10ps

module fpi_tb
   import fpi_pkg::*;
();

   localparam int MAX_INSTR    = 128;
   // Room for the last multiplies to come back after the final instruction
   localparam int DRAIN_CYCLES = 400;

   logic                         clk;
   logic                         reset;
   logic                         instr_valid_i;
   logic                         instr_ready_o;
   logic [XLEN_GP-1:0]           instr_i;
   logic [XLEN_GP-1:0]           int_operand_i;
   logic                         wb_valid_o;
   logic [REG_ADDR_WIDTH_GP-1:0] wb_rd_o;
   logic [XLEN_GP-1:0]           wb_data_o;
   logic                         wb_to_int_o;

   // Stimulus table, one row per instruction
   logic [31:0] stim_instr [MAX_INSTR];
   logic [31:0] stim_op    [MAX_INSTR];
   logic [4:0]  stim_dest  [MAX_INSTR];
   logic [31:0] stim_value [MAX_INSTR];
   logic        stim_int   [MAX_INSTR];
   int          n_instr;
   logic        loaded;

   // Expected values per destination, index is {to_int, rd}
   logic [31:0] exp_q [64][$];
   int          wb_count;

   fpi_top u_fpi_top (
      .clk           (clk),
      .reset         (reset),
      .instr_valid_i (instr_valid_i),
      .instr_ready_o (instr_ready_o),
      .instr_i       (instr_i),
      .int_operand_i (int_operand_i),
      .wb_valid_o    (wb_valid_o),
      .wb_rd_o       (wb_rd_o),
      .wb_data_o     (wb_data_o),
      .wb_to_int_o   (wb_to_int_o)
   );

   always #50 clk = ~clk;

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
      if (got !== expected)
      begin
         $display("Error: time %0t %s got %h expected %h", $time, name, got, expected);
         $display("Result: FAILED");
         $fatal(1, "value mismatch");
      end
   endtask

   task automatic load_stimulus();
      int    fd;
      int    cnt;
      string line;
      logic [31:0] w, op, dest, val, to_int;
      fd = $fopen("dv/fpi_stimulus.txt", "r");
      if (fd == 0)
      begin
         $display("Could not open the stimulus file dv/fpi_stimulus.txt");
         $display("Result: FAILED");
         $fatal(1, "missing stimulus");
      end
      n_instr = 0;
      while (!$feof(fd) && n_instr < MAX_INSTR)
      begin
         line = "";
         void'($fgets(line, fd));
         // Skip comment and blank lines
         if (line.len() == 0 || line.getc(0) == "#")
            continue;
         cnt = $sscanf(line, "%h %h %h %h %h", w, op, dest, val, to_int);
         if (cnt != 5)
            continue;
         stim_instr[n_instr] = w;
         stim_op[n_instr]    = op;
         stim_dest[n_instr]  = dest[4:0];
         stim_value[n_instr] = val;
         stim_int[n_instr]   = to_int[0];
         n_instr++;
      end
      $fclose(fd);
   endtask

   // Holds valid and data until the DUT takes the instruction
   task automatic send_instr(input int idx);
      logic done;
      done          = 1'b0;
      instr_valid_i = 1'b1;
      instr_i       = stim_instr[idx];
      int_operand_i = stim_op[idx];
      while (!done)
      begin
         @(negedge clk);
         done = instr_ready_o;
         @(posedge clk);
         #1;
      end
      instr_valid_i = 1'b0;
   endtask

   task automatic take_writeback();
      int    key;
      string name;
      logic [31:0] expected;
      key  = int'({wb_to_int_o, wb_rd_o});
      name = $sformatf("wb_data_o (%s%0d)", wb_to_int_o ? "x" : "f", wb_rd_o);
      if (exp_q[key].size() == 0)
      begin
         $display("Unexpected writeback to %s at time %0t", name, $time);
         $display("Result: FAILED");
         $fatal(1, "unexpected writeback");
      end
      expected = exp_q[key].pop_front();
      check_value(name, wb_data_o, expected);
      wb_count++;
   endtask

   // Outputs are sampled mid-cycle where they are settled
   always @(negedge clk)
   begin
      if (!reset && wb_valid_o)
         take_writeback();
   end

   initial
   begin
      wait (loaded);
      repeat (n_instr * 40) @(posedge clk);
      $display("Timeout: the DUT did not finish all %0d instructions in time", n_instr);
      $display("Result: FAILED");
      $fatal(1, "watchdog expired");
   end

   initial
   begin
      int leftover;
      int drain;
      clk           = 1'b0;
      reset         = 1'b1;
      instr_valid_i = 1'b0;
      instr_i       = '0;
      int_operand_i = '0;
      loaded        = 1'b0;
      wb_count      = 0;
      leftover      = 0;
      drain         = 0;
      void'($urandom(32'hb660));

      load_stimulus();
      for (int i = 0; i < n_instr; i++)
         exp_q[int'({stim_int[i], stim_dest[i]})].push_back(stim_value[i]);
      loaded = 1'b1;

      repeat (4) @(posedge clk);
      #1;
      reset = 1'b0;

      for (int i = 0; i < n_instr; i++)
      begin
         // Random gaps between instructions
         if ($urandom % 4 == 0)
         begin
            @(posedge clk);
            #1;
         end
         send_instr(i);
      end

      // Outstanding writebacks, bounded wait
      while (wb_count < n_instr && drain < DRAIN_CYCLES)
      begin
         @(negedge clk);
         drain++;
      end
      repeat (5) @(posedge clk);

      for (int k = 0; k < 64; k++)
         leftover += exp_q[k].size();
      if (leftover != 0)
      begin
         $display("%0d expected writebacks never arrived", leftover);
         $display("Result: FAILED");
         $fatal(1, "missing writebacks");
      end
      else
      begin
         $display("Result: PASSED");
         $finish;
      end
   end

endmodule

// File: run.sh
#!/bin/sh
# Build with Verilator and run from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f build.f --top-module fpi_tb -o fpi_sim || exit 1
./obj_dir/fpi_sim | tee /dev/stderr | grep -q "Result: PASSED" && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

// File: verilog/fam_ifs.sv
`timescale 1ns/10ps

// Multiply request stream, valid/ready
interface fam_req_if
   import fpi_pkg::*;
();
   logic     valid;
   logic     ready;
   fam_req_s data;

   modport issue     (output valid, output data, input  ready);
   modport queue_in  (input  valid, input  data, output ready);
   modport queue_out (output valid, output data, input  ready);
   modport mul       (input  valid, input  data, output ready);
endinterface

// Multiply result, held until yumi
interface fam_rsp_if
   import fpi_pkg::*;
();
   logic                         valid;
   logic [REG_ADDR_WIDTH_GP-1:0] rd;
   logic [XLEN_GP-1:0]           data;
   f_fflags_s                    flags;
   logic                         yumi;

   modport mul   (output valid, output rd, output data, output flags, input  yumi);
   modport issue (input  valid, input  rd, input  data, input  flags, output yumi);
endinterface

// File: verilog/fam_mul.sv
`timescale 1ns/10ps

module fam_mul
   import fpi_pkg::*;
(
   input  logic   clk,
   input  logic   reset,
   fam_req_if.mul req,
   fam_rsp_if.mul rsp
);

   // Steps 0..23 multiply, then one normalize and one pack cycle
   localparam logic [4:0] NORM_CYCLE = 5'd24;
   localparam logic [4:0] PACK_CYCLE = 5'd25;

   logic                         busy_r, rsp_valid_r, accept;
   logic [4:0]                   cnt_r;
   logic [XLEN_GP-1:0]           a, b, special_val;
   logic a_zero, b_zero, a_inf, b_inf, any_nan, inf_zero, special;
   f_fflags_s                    special_flags;

   logic                         sign_r, special_r, sticky_r;
   logic [23:0]                  ma_r, mb_r;
   logic [47:0]                  acc_r;
   logic [24:0]                  step_sum;
   logic signed [9:0]            exp_r;
   logic [22:0]                  mant_r;
   logic [REG_ADDR_WIDTH_GP-1:0] rd_r;
   logic [XLEN_GP-1:0]           data_r;
   f_fflags_s                    flags_r;

   assign a = req.data.a;
   assign b = req.data.b;

   // Zero exponent covers subnormals, flushed here
   assign a_zero   = a[30:23] == 8'h00;
   assign b_zero   = b[30:23] == 8'h00;
   assign a_inf    = (a[30:23] == 8'hFF) & (a[22:0] == '0);
   assign b_inf    = (b[30:23] == 8'hFF) & (b[22:0] == '0);
   assign any_nan  = is_nan(a) | is_nan(b);
   assign inf_zero = (a_inf & b_zero) | (a_zero & b_inf);
   assign special  = any_nan | a_inf | b_inf | a_zero | b_zero;

   always_comb
   begin
      special_flags = '0;
      if (any_nan | inf_zero)
      begin
         special_val      = CANON_NAN;
         special_flags.nv = inf_zero | is_snan(a) | is_snan(b);
      end
      else if (a_inf | b_inf)
         special_val = {a[31] ^ b[31], 8'hFF, 23'b0};
      else
         special_val = {a[31] ^ b[31], 31'b0};
   end

   // One shift-add step, partial product shifts right
   assign step_sum = {1'b0, acc_r[47:24]} + (mb_r[0] ? {1'b0, ma_r} : 25'b0);

   assign req.ready = ~busy_r;
   assign accept    = req.valid & ~busy_r;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         busy_r      <= 1'b0;
         rsp_valid_r <= 1'b0;
         cnt_r       <= '0;
      end
      else if (accept)
      begin
         busy_r <= 1'b1;
         cnt_r  <= '0;
      end
      else if (rsp_valid_r)
      begin
         if (rsp.yumi)
         begin
            busy_r      <= 1'b0;
            rsp_valid_r <= 1'b0;
         end
      end
      else if (busy_r)
      begin
         cnt_r <= cnt_r + 1'b1;
         if (cnt_r == PACK_CYCLE)
            rsp_valid_r <= 1'b1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (accept)
      begin
         rd_r      <= req.data.rd;
         sign_r    <= a[31] ^ b[31];
         special_r <= special;
         data_r    <= special_val;
         flags_r   <= special_flags;
         ma_r      <= {1'b1, a[22:0]};
         mb_r      <= {1'b1, b[22:0]};
         acc_r     <= '0;
         exp_r     <= $signed({2'b00, a[30:23]}) + $signed({2'b00, b[30:23]});
      end
      else if (busy_r & ~rsp_valid_r)
      begin
         if (cnt_r < NORM_CYCLE)
         begin
            acc_r <= {step_sum, acc_r[23:1]};
            mb_r  <= mb_r >> 1;
         end
         else if (cnt_r == NORM_CYCLE)
         begin
            // Product in [1,4), drop the leading one and truncate
            if (acc_r[47])
            begin
               mant_r   <= acc_r[46:24];
               sticky_r <= |acc_r[23:0];
               exp_r    <= exp_r - 10'sd126;
            end
            else
            begin
               mant_r   <= acc_r[45:23];
               sticky_r <= |acc_r[22:0];
               exp_r    <= exp_r - 10'sd127;
            end
         end
         else if (~special_r)
         begin
            if (exp_r > 10'sd254)
            begin
               data_r  <= {sign_r, 8'hFE, 23'h7F_FFFF};
               flags_r <= '{nv: 1'b0, dz: 1'b0, of: 1'b1, uf: 1'b0, nx: 1'b1};
            end
            else if (exp_r < 10'sd1)
            begin
               data_r  <= {sign_r, 31'b0};
               flags_r <= '{nv: 1'b0, dz: 1'b0, of: 1'b0, uf: 1'b1, nx: 1'b1};
            end
            else
            begin
               data_r  <= {sign_r, exp_r[7:0], mant_r};
               flags_r <= '{nv: 1'b0, dz: 1'b0, of: 1'b0, uf: 1'b0, nx: sticky_r};
            end
         end
      end
   end

   assign rsp.valid = rsp_valid_r;
   assign rsp.rd    = rd_r;
   assign rsp.data  = data_r;
   assign rsp.flags = flags_r;

endmodule

// File: verilog/fam_queue.sv
`timescale 1ns/10ps

module fam_queue
   import fpi_pkg::*;
#(
   parameter int QUEUE_DEPTH = 2
)
(
   input  logic        clk,
   input  logic        reset,
   fam_req_if.queue_in  enq,
   fam_req_if.queue_out deq
);

   localparam int PTR_W = $clog2(QUEUE_DEPTH);
   localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);
   localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(QUEUE_DEPTH - 1);
   localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(QUEUE_DEPTH);

   fam_req_s         mem_r [QUEUE_DEPTH];
   logic [PTR_W-1:0] wptr_r, rptr_r;
   logic [CNT_W-1:0] count_r;
   logic             do_enq, do_deq;

   // Wrap at the depth, which need not be a power of two
   function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
      return (p == LAST_PTR) ? '0 : p + 1'b1;
   endfunction

   assign enq.ready = count_r != FULL_CNT;
   assign deq.valid = count_r != '0;
   assign deq.data  = mem_r[rptr_r];
   assign do_enq    = enq.valid & enq.ready;
   assign do_deq    = deq.valid & deq.ready;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         wptr_r  <= '0;
         rptr_r  <= '0;
         count_r <= '0;
      end
      else
      begin
         if (do_enq)
            wptr_r <= next_ptr(wptr_r);
         if (do_deq)
            rptr_r <= next_ptr(rptr_r);
         if (do_enq & ~do_deq)
            count_r <= count_r + 1'b1;
         else if (do_deq & ~do_enq)
            count_r <= count_r - 1'b1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (do_enq)
         mem_r[wptr_r] <= enq.data;
   end

endmodule

// File: verilog/fp_issue.sv
`timescale 1ns/10ps

module fp_issue
   import fpi_pkg::*;
(
   input  logic                         clk,
   input  logic                         reset,
   input  logic                         instr_valid_i,
   output logic                         instr_ready_o,
   input  f_instr_u                     instr_i,
   input  logic [XLEN_GP-1:0]           int_operand_i,
   output logic                         wb_valid_o,
   output logic [REG_ADDR_WIDTH_GP-1:0] wb_rd_o,
   output logic [XLEN_GP-1:0]           wb_data_o,
   output logic                         wb_to_int_o,
   fam_req_if.issue                     fam_req,
   fam_rsp_if.issue                     fam_rsp
);

   logic [XLEN_GP-1:0]           frf_r [32];
   logic [31:0]                  pending_r;
   f_fflags_s                    fflags_r;

   logic                         id_valid_r;
   f_instr_u                     id_instr_r;
   logic [XLEN_GP-1:0]           id_int_r;
   logic id_fp, id_sgnj, id_minmax, id_mul, id_mvxw, id_mvwx, id_frflags;
   logic id_reads1, id_reads2, id_writes_f, sb_hazard, id_adv;
   logic [REG_ADDR_WIDTH_GP-1:0] src_addr [2];
   logic [XLEN_GP-1:0]           src_val [2];

   logic exe_valid_r, exe_sgnj_r, exe_minmax_r, exe_mul_r, exe_frflags_r;
   logic exe_wb_r, exe_to_int_r, exe_hold, exe_to_wb, exe_fwd, a_lt_b;
   logic [2:0]                   exe_funct3_r;
   logic [REG_ADDR_WIDTH_GP-1:0] exe_rd_r;
   logic [XLEN_GP-1:0]           exe_a_r, exe_b_r, exe_result;
   f_fflags_s                    exe_flags;

   logic                         wb_valid_r, wb_to_int_r, wb_wen;
   logic [REG_ADDR_WIDTH_GP-1:0] wb_rd_r;
   logic [XLEN_GP-1:0]           wb_data_r;

   ////////////////////////////////////////
   // ID stage: decode and operand read
   ////////////////////////////////////////

   assign id_fp      = id_instr_r.r.opcode == OPC_OP_FP;
   assign id_sgnj    = id_fp & (id_instr_r.r.funct7 == F7_FSGNJ);
   assign id_minmax  = id_fp & (id_instr_r.r.funct7 == F7_FMINMAX);
   assign id_mul     = id_fp & (id_instr_r.r.funct7 == F7_FMUL);
   assign id_mvxw    = id_fp & (id_instr_r.r.funct7 == F7_FMV_X_W);
   assign id_mvwx    = id_fp & (id_instr_r.r.funct7 == F7_FMV_W_X);
   assign id_frflags = (id_instr_r.csr.opcode == OPC_SYSTEM)
                     & (id_instr_r.csr.csr_addr == CSR_ADDR_FFLAGS)
                     & (id_instr_r.csr.funct3 == F3_CSRRS)
                     & (id_instr_r.csr.rs1 == '0);

   assign id_reads1   = id_sgnj | id_minmax | id_mul | id_mvxw;
   assign id_reads2   = id_sgnj | id_minmax | id_mul;
   assign id_writes_f = id_sgnj | id_minmax | id_mul | id_mvwx;

   // Wait on any register still owed by the multiplier
   assign sb_hazard = (id_reads1 & pending_r[id_instr_r.r.rs1])
                    | (id_reads2 & pending_r[id_instr_r.r.rs2])
                    | (id_writes_f & pending_r[id_instr_r.r.rd])
                    | (id_frflags & (|pending_r));

   assign id_adv        = id_valid_r & ~sb_hazard & ~exe_hold;
   assign instr_ready_o = ~id_valid_r | id_adv;

   assign src_addr[0] = id_instr_r.r.rs1;
   assign src_addr[1] = id_instr_r.r.rs2;

   // EXE result is younger than the WB write, so it wins
   always_comb
   begin
      for (int i = 0; i < 2; i++)
      begin
         if (exe_fwd & (exe_rd_r == src_addr[i]))
            src_val[i] = exe_result;
         else if (wb_wen & (wb_rd_r == src_addr[i]))
            src_val[i] = wb_data_r;
         else
            src_val[i] = frf_r[src_addr[i]];
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         id_valid_r <= 1'b0;
      else if (instr_ready_o)
         id_valid_r <= instr_valid_i;
   end

   always_ff @(posedge clk)
   begin
      if (instr_ready_o & instr_valid_i)
      begin
         id_instr_r <= instr_i;
         id_int_r   <= int_operand_i;
      end
   end

   ////////////////////////////////////////
   // EXE stage: short ops, FMUL dispatch
   ////////////////////////////////////////

   // A short op yields to a multiplier result arriving at WB
   assign exe_hold  = exe_valid_r & (exe_mul_r ? ~fam_req.ready : fam_rsp.valid);
   assign exe_to_wb = exe_valid_r & exe_wb_r & ~exe_hold;
   assign exe_fwd   = exe_valid_r & exe_wb_r & ~exe_to_int_r;

   // Sign-magnitude order, -0 sorts below +0
   assign a_lt_b = (exe_a_r[31] != exe_b_r[31]) ? exe_a_r[31]
                 : (exe_a_r[31] ^ (exe_a_r[30:0] < exe_b_r[30:0]));

   always_comb
   begin
      exe_flags  = '0;
      exe_result = exe_a_r;
      if (exe_sgnj_r)
      begin
         case (exe_funct3_r)
            3'd0:    exe_result = {exe_b_r[31], exe_a_r[30:0]};
            3'd1:    exe_result = {~exe_b_r[31], exe_a_r[30:0]};
            default: exe_result = {exe_a_r[31] ^ exe_b_r[31], exe_a_r[30:0]};
         endcase
      end
      else if (exe_minmax_r)
      begin
         exe_flags.nv = is_snan(exe_a_r) | is_snan(exe_b_r);
         if (is_nan(exe_a_r) & is_nan(exe_b_r))
            exe_result = CANON_NAN;
         else if (is_nan(exe_a_r))
            exe_result = exe_b_r;
         else if (is_nan(exe_b_r))
            exe_result = exe_a_r;
         else
            exe_result = (a_lt_b ^ exe_funct3_r[0]) ? exe_a_r : exe_b_r;
      end
      else if (exe_frflags_r)
         exe_result = {{(XLEN_GP-5){1'b0}}, fflags_r};
   end

   assign fam_req.valid = exe_valid_r & exe_mul_r;
   assign fam_req.data  = '{rd: exe_rd_r, a: exe_a_r, b: exe_b_r};

   always_ff @(posedge clk)
   begin
      if (reset)
         exe_valid_r <= 1'b0;
      else if (~exe_hold)
         exe_valid_r <= id_adv;
   end

   always_ff @(posedge clk)
   begin
      if (id_adv)
      begin
         exe_sgnj_r    <= id_sgnj;
         exe_minmax_r  <= id_minmax;
         exe_mul_r     <= id_mul;
         exe_frflags_r <= id_frflags;
         exe_wb_r      <= id_sgnj | id_minmax | id_mvwx | id_mvxw | id_frflags;
         exe_to_int_r  <= id_mvxw | id_frflags;
         exe_funct3_r  <= id_instr_r.r.funct3;
         exe_rd_r      <= id_instr_r.r.rd;
         exe_a_r       <= id_mvwx ? id_int_r : src_val[0];
         exe_b_r       <= src_val[1];
      end
   end

   ////////////////////////////////////////
   // WB stage, scoreboard and fflags
   ////////////////////////////////////////

   assign fam_rsp.yumi = fam_rsp.valid;
   assign wb_wen       = wb_valid_r & ~wb_to_int_r;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         wb_valid_r <= 1'b0;
         pending_r  <= '0;
         fflags_r   <= '0;
      end
      else
      begin
         wb_valid_r <= fam_rsp.valid | exe_to_wb;
         if (fam_rsp.valid)
            pending_r[fam_rsp.rd] <= 1'b0;
         if (id_adv & id_mul)
            pending_r[id_instr_r.r.rd] <= 1'b1;
         fflags_r <= fflags_r | (fam_rsp.valid ? fam_rsp.flags : '0)
                   | (exe_to_wb ? exe_flags : '0);
      end
   end

   always_ff @(posedge clk)
   begin
      if (fam_rsp.valid)
      begin
         wb_rd_r     <= fam_rsp.rd;
         wb_data_r   <= fam_rsp.data;
         wb_to_int_r <= 1'b0;
      end
      else if (exe_to_wb)
      begin
         wb_rd_r     <= exe_rd_r;
         wb_data_r   <= exe_result;
         wb_to_int_r <= exe_to_int_r;
      end
      if (wb_wen)
         frf_r[wb_rd_r] <= wb_data_r;
   end

   assign wb_valid_o  = wb_valid_r;
   assign wb_rd_o     = wb_rd_r;
   assign wb_data_o   = wb_data_r;
   assign wb_to_int_o = wb_to_int_r;

endmodule

// File: verilog/fpi_pkg.sv
package fpi_pkg;

   // Widths
   localparam int XLEN_GP           = 32;
   localparam int REG_ADDR_WIDTH_GP = 5;

   // Major opcodes
   localparam logic [6:0] OPC_OP_FP  = 7'b1010011;
   localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

   // funct7 per operation
   localparam logic [6:0] F7_FSGNJ   = 7'b0010000;
   localparam logic [6:0] F7_FMINMAX = 7'b0010100;
   localparam logic [6:0] F7_FMUL    = 7'b0001000;
   localparam logic [6:0] F7_FMV_X_W = 7'b1110000;
   localparam logic [6:0] F7_FMV_W_X = 7'b1111000;

   // FRFLAGS is CSRRS rd, fflags, x0
   localparam logic [2:0]  F3_CSRRS        = 3'b010;
   localparam logic [11:0] CSR_ADDR_FFLAGS = 12'h001;

   localparam logic [XLEN_GP-1:0] CANON_NAN = 32'h7FC0_0000;

   // One instruction word, two field layouts
   typedef union packed {
      struct packed {
         logic [6:0]                   funct7;
         logic [REG_ADDR_WIDTH_GP-1:0] rs2;
         logic [REG_ADDR_WIDTH_GP-1:0] rs1;
         logic [2:0]                   funct3;
         logic [REG_ADDR_WIDTH_GP-1:0] rd;
         logic [6:0]                   opcode;
      } r;
      struct packed {
         logic [11:0]                  csr_addr;
         logic [REG_ADDR_WIDTH_GP-1:0] rs1;
         logic [2:0]                   funct3;
         logic [REG_ADDR_WIDTH_GP-1:0] rd;
         logic [6:0]                   opcode;
      } csr;
   } f_instr_u;

   // Bit order matches fflags, nv is bit 4
   typedef struct packed {
      logic nv;
      logic dz;
      logic of;
      logic uf;
      logic nx;
   } f_fflags_s;

   typedef struct packed {
      logic [REG_ADDR_WIDTH_GP-1:0] rd;
      logic [XLEN_GP-1:0]           a;
      logic [XLEN_GP-1:0]           b;
   } fam_req_s;

   function automatic logic is_nan(input logic [XLEN_GP-1:0] x);
      return (x[30:23] == 8'hFF) && (x[22:0] != '0);
   endfunction

   // Quiet bit clear marks a signaling NaN
   function automatic logic is_snan(input logic [XLEN_GP-1:0] x);
      return is_nan(x) && !x[22];
   endfunction

endpackage

// File: verilog/fpi_top.sv
`timescale 1ns/10ps

module fpi_top
   import fpi_pkg::*;
#(
   parameter int QUEUE_DEPTH = 2
)
(
   input  logic                         clk,
   input  logic                         reset,
   input  logic                         instr_valid_i,
   output logic                         instr_ready_o,
   input  logic [XLEN_GP-1:0]           instr_i,
   input  logic [XLEN_GP-1:0]           int_operand_i,
   output logic                         wb_valid_o,
   output logic [REG_ADDR_WIDTH_GP-1:0] wb_rd_o,
   output logic [XLEN_GP-1:0]           wb_data_o,
   output logic                         wb_to_int_o
);

   // Issue to queue, queue to multiplier, multiplier back to issue
   fam_req_if issue_req ();
   fam_req_if mul_req ();
   fam_rsp_if mul_rsp ();

   fp_issue u_issue (
      .clk           (clk),
      .reset         (reset),
      .instr_valid_i (instr_valid_i),
      .instr_ready_o (instr_ready_o),
      .instr_i       (instr_i),
      .int_operand_i (int_operand_i),
      .wb_valid_o    (wb_valid_o),
      .wb_rd_o       (wb_rd_o),
      .wb_data_o     (wb_data_o),
      .wb_to_int_o   (wb_to_int_o),
      .fam_req       (issue_req),
      .fam_rsp       (mul_rsp)
   );

   fam_queue #(
      .QUEUE_DEPTH (QUEUE_DEPTH)
   ) u_queue (
      .clk   (clk),
      .reset (reset),
      .enq   (issue_req),
      .deq   (mul_req)
   );

   fam_mul u_mul (
      .clk   (clk),
      .reset (reset),
      .req   (mul_req),
      .rsp   (mul_rsp)
   );

endmodule
